/* rtl/board_consts.svh */
//##############################
// Board glue constants
// Widths, status bits and hold times
//##############################

`ifndef BOARD_CONSTS_SVH
`define BOARD_CONSTS_SVH

// Data widths
`define COLORW                  4
`define BOARD_JOYW              16
`define GAME_JOYW               10
`define APB_ADDRW               12
`define APB_DATAW               32

// Game input options, up to 6 buttons
`define GAME_BUTTONS            2
`define GAME_INPUTS_ACTIVE_LOW  1

// Hold times in clk_sys cycles
`define BOARD_RST_HOLD          16
`define GAME_RST_HOLD           32
`define SOFT_RST_HOLD           64

// Download blink period in frames
`define LED_BLINK_FRAMES        4

// Settings word and its bit positions
`define STATUS_RESET            32'h0
`define ST_ROTATE               0
`define ST_FLIP                 1
`define ST_TEST                 2
`define ST_PAUSE                3
`define ST_FX_LO                4
`define ST_NOFM                 6
`define ST_NOPSG                7

`define APB_STATUS_ADDR         12'h000

`endif

/* rtl/board_pkg.sv */
//##############################
// Board glue types
// Reset, inputs, settings and APB
//##############################

package board_pkg;

`include "board_consts.svh"

    // Platform joystick, active high
    // [0] right [1] left [2] down [3] up, [9:4] buttons 1-6, [10] coin, [11] start
    typedef logic [`BOARD_JOYW-1:0] board_joy_t;

    // Same layout as board_joy_t[9:0], game polarity
    typedef logic [`GAME_JOYW-1:0] game_joy_t;

    typedef logic [`APB_DATAW-1:0] status_t;
    typedef logic [`APB_ADDRW-1:0] apb_addr_t;

    // Decoded DIP switches
    typedef struct packed {
        logic       rot_control;
        logic       flip;
        logic       test;
        logic       pause;
        logic [1:0] fxlevel;
        logic       enable_fm;
        logic       enable_psg;
    } dip_cfg_t;

    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        status_t   pwdata;
    } apb_req_t;

    typedef struct packed {
        status_t prdata;
        logic    pready;
        logic    pslverr;
    } apb_rsp_t;

    typedef enum logic [1:0] {
        GRST_HOLD,
        GRST_COUNT,
        GRST_RUN
    } game_rst_e;

endpackage

/* rtl/video_pkg.sv */
//##############################
// Video types
// Colour channels and pixel bundles
//##############################

package video_pkg;

`include "board_consts.svh"

    typedef logic [`COLORW-1:0] color_t;
    typedef logic [7:0]         color8_t;

    // Pixel as the game core produces it, blanking active low
    typedef struct packed {
        color_t r;
        color_t g;
        color_t b;
        logic   hs;
        logic   vs;
        logic   lhbl;
        logic   lvbl;
    } pixel_in_t;

    typedef struct packed {
        color8_t r;
        color8_t g;
        color8_t b;
        logic    hs;
        logic    vs;
        logic    de;
    } pixel_out_t;

endpackage

/* rtl/board_reset.sv */
//##############################
// Reset sequencer
// Board reset after PLL lock, game reset on requests
//##############################

`timescale 1ns/1ps

`include "board_consts.svh"

module board_reset (
    input  logic                clk_sys,
    input  logic                rst_n,
    input  logic                pll_locked,
    input  logic                rst_req,
    input  logic                downloading,
    input  logic                soft_rst,
    input  board_pkg::dip_cfg_t dip_cfg,
    output logic                board_rst,
    output logic                game_rst_n
);

    localparam int BCNTW = $clog2(`BOARD_RST_HOLD);
    localparam int GCNTW = $clog2(`GAME_RST_HOLD);

    logic [BCNTW-1:0]     board_cnt;
    logic [GCNTW-1:0]     game_cnt;
    logic                 flip_q;
    logic                 flip_chg;
    logic                 game_req;
    board_pkg::game_rst_e state;

    // Board reset waits for a stable lock
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            board_rst <= 1'b1;
            board_cnt <= '0;
        end else if (!pll_locked) begin
            board_rst <= 1'b1;
            board_cnt <= '0;
        end else if (board_rst) begin
            if (board_cnt == BCNTW'(`BOARD_RST_HOLD - 1)) begin
                board_rst <= 1'b0;
            end else begin
                board_cnt <= board_cnt + 1'b1;
            end
        end
    end

    // Lost lock resets the game on the same edge as the board
    assign flip_chg = dip_cfg.flip != flip_q;
    assign game_req = ~pll_locked | board_rst | downloading | rst_req | soft_rst | flip_chg;

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            flip_q   <= 1'b0;
            state    <= board_pkg::GRST_HOLD;
            game_cnt <= '0;
        end else begin
            flip_q <= dip_cfg.flip;
            if (game_req) begin
                state    <= board_pkg::GRST_HOLD;
                game_cnt <= '0;
            end else begin
                case (state)
                    board_pkg::GRST_HOLD: begin
                        state    <= board_pkg::GRST_COUNT;
                        game_cnt <= GCNTW'(1);
                    end
                    board_pkg::GRST_COUNT: begin
                        if (game_cnt == GCNTW'(`GAME_RST_HOLD - 1)) begin
                            state <= board_pkg::GRST_RUN;
                        end else begin
                            game_cnt <= game_cnt + 1'b1;
                        end
                    end
                    default: begin
                        state <= board_pkg::GRST_RUN;
                    end
                endcase
            end
        end
    end

    assign game_rst_n = state == board_pkg::GRST_RUN;

endmodule

/* rtl/board_inputs.sv */
//##############################
// Player input mapping
// Polarity, masking, rotation, soft reset
//##############################

`timescale 1ns/1ps

`include "board_consts.svh"

module board_inputs #(
    parameter int BUTTONS = `GAME_BUTTONS
) (
    input  logic                  clk_sys,
    input  logic                  rst_n,
    input  logic                  downloading,
    input  board_pkg::dip_cfg_t   dip_cfg,
    input  board_pkg::board_joy_t board_joy1,
    input  board_pkg::board_joy_t board_joy2,
    output board_pkg::game_joy_t  game_joy1,
    output board_pkg::game_joy_t  game_joy2,
    output logic [1:0]            game_coin,
    output logic [1:0]            game_start,
    output logic                  game_service,
    output logic                  soft_rst
);

    localparam int         JOY_COIN  = 10;
    localparam int         JOY_START = 11;
    localparam logic [5:0] BTN_MASK  = 6'((1 << BUTTONS) - 1);
    localparam logic       INV       = `GAME_INPUTS_ACTIVE_LOW;
    localparam int         SCNTW     = $clog2(`SOFT_RST_HOLD);

    board_pkg::game_joy_t joy1_act;
    board_pkg::game_joy_t joy2_act;
    logic [1:0]           coin_act;
    logic [1:0]           start_act;
    logic                 service_act;
    logic                 sr_combo;
    logic                 sr_armed;
    logic [SCNTW-1:0]     sr_cnt;

    // Active high mapping of one stick
    function automatic board_pkg::game_joy_t map_joy(
        input board_pkg::board_joy_t bj,
        input logic                  rot
    );
        board_pkg::game_joy_t j;
        j[9:4] = bj[9:4] & BTN_MASK;
        // Rotated: right=up, left=down, down=right, up=left
        if (rot) begin
            j[3:0] = {bj[1], bj[0], bj[2], bj[3]};
        end else begin
            j[3:0] = bj[3:0];
        end
        return j;
    endfunction

    always_comb begin
        joy1_act    = map_joy(board_joy1, dip_cfg.rot_control);
        joy2_act    = map_joy(board_joy2, dip_cfg.rot_control);
        coin_act    = {board_joy2[JOY_COIN], board_joy1[JOY_COIN]};
        start_act   = {board_joy2[JOY_START], board_joy1[JOY_START]};
        service_act = board_joy1[JOY_START] & board_joy2[JOY_COIN];
        // Game sees nothing while the ROM loads
        if (downloading) begin
            joy1_act    = '0;
            joy2_act    = '0;
            coin_act    = '0;
            start_act   = '0;
            service_act = 1'b0;
        end
    end

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            game_joy1    <= {`GAME_JOYW{INV}};
            game_joy2    <= {`GAME_JOYW{INV}};
            game_coin    <= {2{INV}};
            game_start   <= {2{INV}};
            game_service <= INV;
        end else begin
            game_joy1    <= joy1_act ^ {`GAME_JOYW{INV}};
            game_joy2    <= joy2_act ^ {`GAME_JOYW{INV}};
            game_coin    <= coin_act ^ {2{INV}};
            game_start   <= start_act ^ {2{INV}};
            game_service <= service_act ^ INV;
        end
    end

    // Start and coin held on player 1, re-armed on release
    assign sr_combo = board_joy1[JOY_START] & board_joy1[JOY_COIN];

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            sr_cnt   <= '0;
            sr_armed <= 1'b1;
            soft_rst <= 1'b0;
        end else begin
            soft_rst <= 1'b0;
            if (!sr_combo) begin
                sr_cnt   <= '0;
                sr_armed <= 1'b1;
            end else if (sr_armed) begin
                if (sr_cnt == SCNTW'(`SOFT_RST_HOLD - 1)) begin
                    soft_rst <= 1'b1;
                    sr_armed <= 1'b0;
                end else begin
                    sr_cnt <= sr_cnt + 1'b1;
                end
            end
        end
    end

endmodule

/* rtl/board_dip.sv */
//##############################
// Settings register
// APB status word and DIP decode
//##############################

`timescale 1ns/1ps

`include "board_consts.svh"

module board_dip (
    input  logic                clk_sys,
    input  logic                rst_n,
    input  board_pkg::apb_req_t apb_req,
    output board_pkg::apb_rsp_t apb_rsp,
    output board_pkg::dip_cfg_t dip_cfg
);

    board_pkg::status_t status;
    logic               addr_hit;
    logic               access;
    logic               wr_en;

    assign addr_hit = apb_req.paddr == `APB_STATUS_ADDR;
    assign access   = apb_req.psel & apb_req.penable;
    assign wr_en    = access & apb_req.pwrite & addr_hit;

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            status <= `STATUS_RESET;
        end else if (wr_en) begin
            status <= apb_req.pwdata;
        end
    end

    // No wait states, one valid address
    always_comb begin
        apb_rsp.pready  = 1'b1;
        apb_rsp.pslverr = access & ~addr_hit;
        apb_rsp.prdata  = '0;
        if (apb_req.psel && !apb_req.pwrite && addr_hit) begin
            apb_rsp.prdata = status;
        end
    end

    // Sound enables are stored inverted
    always_comb begin
        dip_cfg.rot_control = status[`ST_ROTATE];
        dip_cfg.flip        = status[`ST_FLIP];
        dip_cfg.test        = status[`ST_TEST];
        dip_cfg.pause       = status[`ST_PAUSE];
        dip_cfg.fxlevel     = status[`ST_FX_LO +: 2];
        dip_cfg.enable_fm   = ~status[`ST_NOFM];
        dip_cfg.enable_psg  = ~status[`ST_NOPSG];
    end

endmodule

/* rtl/board_led.sv */
//##############################
// Status LED
// Blinks while loading, else OSD or game
//##############################

`timescale 1ns/1ps

`include "board_consts.svh"

module board_led (
    input  logic       clk_sys,
    input  logic       board_rst,
    input  logic       lvbl,
    input  logic       downloading,
    input  logic       osd_shown,
    input  logic [1:0] game_led,
    output logic       led
);

    localparam int FCNTW = $clog2(`LED_BLINK_FRAMES);

    logic             lvbl_q;
    logic             frame_end;
    logic             blink;
    logic [FCNTW-1:0] frame_cnt;

    // End of active video
    assign frame_end = lvbl_q & ~lvbl;

    always_ff @(posedge clk_sys or posedge board_rst) begin
        if (board_rst) begin
            lvbl_q    <= 1'b0;
            blink     <= 1'b0;
            frame_cnt <= '0;
            led       <= 1'b0;
        end else begin
            lvbl_q <= lvbl;
            if (!downloading) begin
                blink     <= 1'b0;
                frame_cnt <= '0;
            end else if (frame_end) begin
                if (frame_cnt == FCNTW'(`LED_BLINK_FRAMES - 1)) begin
                    frame_cnt <= '0;
                    blink     <= ~blink;
                end else begin
                    frame_cnt <= frame_cnt + 1'b1;
                end
            end
            led <= downloading ? blink : (osd_shown | game_led[0]);
        end
    end

endmodule

/* rtl/video_expand.sv */
//##############################
// Base video conditioning
// 8-bit colour with blanking, per pixel
//##############################

`timescale 1ns/1ps

`include "board_consts.svh"

module video_expand (
    input  logic                   clk_sys,
    input  logic                   board_rst,
    input  logic                   pxl_cen,
    input  video_pkg::pixel_in_t   pix_in,
    output video_pkg::pixel_out_t  pix_out
);

    logic                  de;
    video_pkg::pixel_out_t pix_nxt;

    // Repeat the channel bits from the MSB down to fill 8 bits
    function automatic video_pkg::color8_t widen(input video_pkg::color_t c);
        video_pkg::color8_t w;
        for (int i = 0; i < 8; i++) begin
            w[7 - i] = c[`COLORW - 1 - (i % `COLORW)];
        end
        return w;
    endfunction

    always_comb begin
        de         = pix_in.lhbl & pix_in.lvbl;
        pix_nxt.r  = de ? widen(pix_in.r) : '0;
        pix_nxt.g  = de ? widen(pix_in.g) : '0;
        pix_nxt.b  = de ? widen(pix_in.b) : '0;
        pix_nxt.hs = pix_in.hs;
        pix_nxt.vs = pix_in.vs;
        pix_nxt.de = de;
    end

    always_ff @(posedge clk_sys or posedge board_rst) begin
        if (board_rst) begin
            pix_out <= '0;
        end else if (pxl_cen) begin
            pix_out <= pix_nxt;
        end
    end

endmodule

/* rtl/board_top.sv */
//##############################
// Board glue top level
// Joins reset, inputs, DIP, LED and video
//##############################

`timescale 1ns/1ps

module board_top (
    input  logic                  clk_sys,
    input  logic                  rst_n,
    input  logic                  pll_locked,
    input  logic                  rst_req,
    input  logic                  downloading,
    input  logic                  osd_shown,
    input  logic [1:0]            game_led,
    input  board_pkg::apb_req_t   apb_req,
    input  board_pkg::board_joy_t board_joy1,
    input  board_pkg::board_joy_t board_joy2,
    input  logic                  pxl_cen,
    input  video_pkg::pixel_in_t  pix_in,
    output board_pkg::apb_rsp_t   apb_rsp,
    output logic                  game_rst_n,
    output logic                  led,
    output board_pkg::game_joy_t  game_joy1,
    output board_pkg::game_joy_t  game_joy2,
    output logic [1:0]            game_coin,
    output logic [1:0]            game_start,
    output logic                  game_service,
    output logic                  dip_test,
    output logic                  dip_pause,
    output logic                  dip_flip,
    output logic [1:0]            dip_fxlevel,
    output logic                  enable_fm,
    output logic                  enable_psg,
    output video_pkg::pixel_out_t pix_out
);

    logic                board_rst;
    logic                soft_rst;
    board_pkg::dip_cfg_t dip_cfg;

    board_reset u_reset (
        .clk_sys     ( clk_sys      ),
        .rst_n       ( rst_n        ),
        .pll_locked  ( pll_locked   ),
        .rst_req     ( rst_req      ),
        .downloading ( downloading  ),
        .soft_rst    ( soft_rst     ),
        .dip_cfg     ( dip_cfg      ),
        .board_rst   ( board_rst    ),
        .game_rst_n  ( game_rst_n   )
    );

    board_inputs u_inputs (
        .clk_sys      ( clk_sys      ),
        .rst_n        ( rst_n        ),
        .downloading  ( downloading  ),
        .dip_cfg      ( dip_cfg      ),
        .board_joy1   ( board_joy1   ),
        .board_joy2   ( board_joy2   ),
        .game_joy1    ( game_joy1    ),
        .game_joy2    ( game_joy2    ),
        .game_coin    ( game_coin    ),
        .game_start   ( game_start   ),
        .game_service ( game_service ),
        .soft_rst     ( soft_rst     )
    );

    board_dip u_dip (
        .clk_sys ( clk_sys ),
        .rst_n   ( rst_n   ),
        .apb_req ( apb_req ),
        .apb_rsp ( apb_rsp ),
        .dip_cfg ( dip_cfg )
    );

    board_led u_led (
        .clk_sys     ( clk_sys     ),
        .board_rst   ( board_rst   ),
        .lvbl        ( pix_in.lvbl ),
        .downloading ( downloading ),
        .osd_shown   ( osd_shown   ),
        .game_led    ( game_led    ),
        .led         ( led         )
    );

    video_expand u_video (
        .clk_sys   ( clk_sys   ),
        .board_rst ( board_rst ),
        .pxl_cen   ( pxl_cen   ),
        .pix_in    ( pix_in    ),
        .pix_out   ( pix_out   )
    );

    // DIP switches out to the core, pause is handled there
    assign dip_test    = dip_cfg.test;
    assign dip_pause   = dip_cfg.pause;
    assign dip_flip    = dip_cfg.flip;
    assign dip_fxlevel = dip_cfg.fxlevel;
    assign enable_fm   = dip_cfg.enable_fm;
    assign enable_psg  = dip_cfg.enable_psg;

endmodule

/* sim/board_checker.sv */
//##############################
// Board glue assertions
// APB, reset and blanking rules
//##############################

`timescale 1ns/1ps

`include "board_consts.svh"

module board_checker (
    input logic                  clk_sys,
    input logic                  rst_n,
    input board_pkg::apb_req_t   apb_req,
    input board_pkg::apb_rsp_t   apb_rsp,
    input logic                  board_rst,
    input logic                  game_rst_n,
    input video_pkg::pixel_out_t pix_out
);

    // Zero wait states on the settings bus
    apb_no_wait: assert property (@(posedge clk_sys) disable iff (!rst_n)
        (apb_req.psel && apb_req.penable) |-> apb_rsp.pready)
        else $error("APB access phase without pready");

    // Only the status word exists
    apb_err_addr: assert property (@(posedge clk_sys) disable iff (!rst_n)
        apb_rsp.pslverr |-> (apb_req.paddr != `APB_STATUS_ADDR))
        else $error("pslverr raised for the status address");

    // Game stays in reset behind the board
    game_behind_board: assert property (@(posedge clk_sys) disable iff (!rst_n)
        board_rst |-> !game_rst_n)
        else $error("game left reset while the board is in reset");

    // Blanked pixels carry no colour
    blank_is_black: assert property (@(posedge clk_sys) disable iff (!rst_n)
        !pix_out.de |-> (pix_out.r == 8'h00 && pix_out.g == 8'h00 && pix_out.b == 8'h00))
        else $error("colour present outside the active area");

endmodule

/* sim/board_tb.sv */
//##############################
// Board glue testbench
// LFSR stimulus against a reference model
//##############################

`timescale 1ns/1ps

`include "board_consts.svh"

module board_tb;

    localparam logic [31:0] SEED          = 32'h93ae456c;
    localparam int          WAIT_LIMIT    = 200;
    localparam logic [15:0] P1_START_COIN = 16'h0c00;

    logic                  clk_sys;
    logic                  rst_n;
    logic                  pll_locked;
    logic                  rst_req;
    logic                  downloading;
    logic                  osd_shown;
    logic [1:0]            game_led;
    board_pkg::apb_req_t   apb_req;
    board_pkg::board_joy_t board_joy1;
    board_pkg::board_joy_t board_joy2;
    logic                  pxl_cen;
    video_pkg::pixel_in_t  pix_in;
    board_pkg::apb_rsp_t   apb_rsp;
    logic                  game_rst_n;
    logic                  led;
    board_pkg::game_joy_t  game_joy1;
    board_pkg::game_joy_t  game_joy2;
    logic [1:0]            game_coin;
    logic [1:0]            game_start;
    logic                  game_service;
    logic                  dip_test;
    logic                  dip_pause;
    logic                  dip_flip;
    logic [1:0]            dip_fxlevel;
    logic                  enable_fm;
    logic                  enable_psg;
    video_pkg::pixel_out_t pix_out;

    board_pkg::status_t    status_model;
    logic [31:0]           lfsr;

    board_top dut_i (.*);

    bind board_top board_checker chk_i (
        .clk_sys    ( clk_sys    ),
        .rst_n      ( rst_n      ),
        .apb_req    ( apb_req    ),
        .apb_rsp    ( apb_rsp    ),
        .board_rst  ( board_rst  ),
        .game_rst_n ( game_rst_n ),
        .pix_out    ( pix_out    )
    );

    always #10 clk_sys = ~clk_sys;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // Expected game stick, active low
    function automatic board_pkg::game_joy_t model_joy(input board_pkg::board_joy_t bj,
                                                      input logic rot,
                                                      input logic dl);
        board_pkg::game_joy_t j;
        j = '0;
        for (int b = 0; b < `GAME_BUTTONS; b++) begin
            j[4 + b] = bj[4 + b];
        end
        if (rot) begin
            j[0] = bj[3];
            j[1] = bj[2];
            j[2] = bj[0];
            j[3] = bj[1];
        end else begin
            j[3:0] = bj[3:0];
        end
        if (dl) begin
            j = '0;
        end
        return ~j;
    endfunction

    function automatic video_pkg::pixel_out_t model_pixel(input video_pkg::pixel_in_t p);
        video_pkg::pixel_out_t o;
        o.de = p.lhbl & p.lvbl;
        o.r  = o.de ? {p.r, p.r} : 8'h00;
        o.g  = o.de ? {p.g, p.g} : 8'h00;
        o.b  = o.de ? {p.b, p.b} : 8'h00;
        o.hs = p.hs;
        o.vs = p.vs;
        return o;
    endfunction

    task automatic stop_run();
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic verify_dips();
        check("dip_flip", dip_flip, status_model[`ST_FLIP]);
        check("dip_test", dip_test, status_model[`ST_TEST]);
        check("dip_pause", dip_pause, status_model[`ST_PAUSE]);
        check("dip_fxlevel", dip_fxlevel, status_model[`ST_FX_LO +: 2]);
        check("enable_fm", enable_fm, !status_model[`ST_NOFM]);
        check("enable_psg", enable_psg, !status_model[`ST_NOPSG]);
    endtask

    task automatic verify_inputs();
        logic       rot;
        logic [1:0] coin_n;
        logic [1:0] start_n;
        logic       service_n;
        rot       = status_model[`ST_ROTATE];
        coin_n    = ~{board_joy2[10], board_joy1[10]};
        start_n   = ~{board_joy2[11], board_joy1[11]};
        service_n = ~(board_joy1[11] & board_joy2[10]);
        if (downloading) begin
            coin_n    = 2'b11;
            start_n   = 2'b11;
            service_n = 1'b1;
        end
        check("game_joy1", game_joy1, model_joy(board_joy1, rot, downloading));
        check("game_joy2", game_joy2, model_joy(board_joy2, rot, downloading));
        check("game_coin", game_coin, coin_n);
        check("game_start", game_start, start_n);
        check("game_service", game_service, service_n);
    endtask

    // Counts falling edges until the game leaves reset
    task automatic await_game_run(input string what, output int n);
        n = 0;
        while (game_rst_n !== 1'b1) begin
            if (n == WAIT_LIMIT) begin
                $display("Timeout: game reset never released after %s", what);
                stop_run();
            end
            @(negedge clk_sys);
            n++;
        end
    endtask

    task automatic await_game_reset(input string what);
        int n;
        n = 0;
        while (game_rst_n !== 1'b0) begin
            if (n == WAIT_LIMIT) begin
                $display("Timeout: game reset never asserted after %s", what);
                stop_run();
            end
            @(negedge clk_sys);
            n++;
        end
    endtask

    // Setup and access phase, called on a falling edge
    task automatic apb_access(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(negedge clk_sys);
        apb_req.penable = 1'b1;
        #1;
        check("pready", apb_rsp.pready, 1'b1);
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(negedge clk_sys);
        apb_req = '0;
    endtask

    task automatic release_after_lock();
        int n;
        repeat (3) @(negedge clk_sys);
        check("game_rst_n", game_rst_n, 1'b0);
        pll_locked = 1'b1;
        await_game_run("PLL lock", n);
        check("game_rst_n edges after lock", n, `BOARD_RST_HOLD + `GAME_RST_HOLD);
        rst_req = 1'b1;
        @(negedge clk_sys);
        rst_req = 1'b0;
        check("game_rst_n", game_rst_n, 1'b0);
        await_game_run("rst_req", n);
        check("game_rst_n edges after rst_req", n, `GAME_RST_HOLD);
    endtask

    task automatic settings_bus();
        logic [31:0] wdata;
        logic [31:0] rdata;
        logic [31:0] rnd;
        logic [11:0] addr;
        logic        err;
        for (int i = 0; i < 16; i++) begin
            wdata = rand_bits(32);
            apb_access(1'b1, `APB_STATUS_ADDR, wdata, rdata, err);
            check("pslverr", err, 1'b0);
            status_model = wdata;
            verify_dips();
            apb_access(1'b0, `APB_STATUS_ADDR, 32'h0, rdata, err);
            check("prdata", rdata, status_model);
            check("pslverr", err, 1'b0);
            verify_dips();
        end
        // Unmapped addresses
        for (int i = 0; i < 8; i++) begin
            rnd   = rand_bits(12);
            addr  = (rnd[11:0] == `APB_STATUS_ADDR) ? 12'h004 : rnd[11:0];
            wdata = rand_bits(32);
            rnd   = rand_bits(1);
            apb_access(rnd[0], addr, wdata, rdata, err);
            check("pslverr", err, 1'b1);
            verify_dips();
        end
    endtask

    task automatic flip_restarts_game();
        logic [31:0] rdata;
        logic        err;
        int          n;
        status_model[`ST_FLIP] = 1'b0;
        apb_access(1'b1, `APB_STATUS_ADDR, status_model, rdata, err);
        @(negedge clk_sys);
        await_game_run("settings writes", n);
        status_model[`ST_FLIP] = 1'b1;
        apb_access(1'b1, `APB_STATUS_ADDR, status_model, rdata, err);
        @(negedge clk_sys);
        check("game_rst_n", game_rst_n, 1'b0);
        await_game_run("flip change", n);
        check("game_rst_n edges after flip", n, `GAME_RST_HOLD);
    endtask

    task automatic joystick_mapping();
        logic [31:0] rdata;
        logic [31:0] rnd;
        logic        err;
        for (int r = 0; r < 2; r++) begin
            status_model[`ST_ROTATE] = r[0];
            apb_access(1'b1, `APB_STATUS_ADDR, status_model, rdata, err);
            for (int i = 0; i < 32; i++) begin
                rnd        = rand_bits(16);
                board_joy1 = rnd[15:0];
                rnd        = rand_bits(16);
                board_joy2 = rnd[15:0];
                @(negedge clk_sys);
                verify_inputs();
            end
        end
        board_joy1 = '0;
        board_joy2 = '0;
        @(negedge clk_sys);
    endtask

    task automatic soft_reset_hold();
        int n;
        check("game_rst_n", game_rst_n, 1'b1);
        // One cycle short of the hold
        board_joy1 = P1_START_COIN;
        for (int i = 0; i < `SOFT_RST_HOLD - 1; i++) begin
            @(negedge clk_sys);
            check("game_rst_n", game_rst_n, 1'b1);
        end
        board_joy1 = '0;
        repeat (4) begin
            @(negedge clk_sys);
            check("game_rst_n", game_rst_n, 1'b1);
        end
        board_joy1 = P1_START_COIN;
        repeat (`SOFT_RST_HOLD) @(negedge clk_sys);
        board_joy1 = '0;
        await_game_reset("start and coin hold");
        await_game_run("soft reset", n);
        check("game_rst_n edges after soft reset", n, `GAME_RST_HOLD);
    endtask

    task automatic video_stream();
        video_pkg::pixel_out_t exp_pix;
        logic [31:0]           rnd;
        exp_pix = '0;
        check("pix_out", pix_out, exp_pix);
        for (int i = 0; i < 200; i++) begin
            rnd     = rand_bits(1);
            pxl_cen = rnd[0];
            rnd     = rand_bits(16);
            pix_in  = rnd[15:0];
            @(negedge clk_sys);
            // Holds when the enable was low
            if (pxl_cen) begin
                exp_pix = model_pixel(pix_in);
            end
            check("pix_out", pix_out, exp_pix);
        end
        pxl_cen = 1'b0;
    endtask

    task automatic led_behaviour();
        logic [31:0] rnd;
        int          n;
        for (int i = 0; i < 16; i++) begin
            rnd       = rand_bits(1);
            osd_shown = rnd[0];
            rnd       = rand_bits(2);
            game_led  = rnd[1:0];
            @(negedge clk_sys);
            check("led", led, osd_shown ? 1'b1 : game_led[0]);
        end
        osd_shown   = 1'b0;
        game_led    = 2'b00;
        pix_in      = '0;
        pix_in.lvbl = 1'b1;
        repeat (2) @(negedge clk_sys);
        downloading = 1'b1;
        repeat (2) @(negedge clk_sys);
        check("led", led, 1'b0);
        for (int f = 1; f <= 3 * `LED_BLINK_FRAMES; f++) begin
            rnd         = rand_bits(16);
            board_joy1  = rnd[15:0];
            rnd         = rand_bits(16);
            board_joy2  = rnd[15:0];
            pix_in.lvbl = 1'b0;
            repeat (3) @(negedge clk_sys);
            verify_inputs();
            pix_in.lvbl = 1'b1;
            repeat (3) @(negedge clk_sys);
            check("led", led, (f / `LED_BLINK_FRAMES) % 2);
        end
        downloading = 1'b0;
        board_joy1  = '0;
        board_joy2  = '0;
        await_game_run("download", n);
        check("game_rst_n edges after download", n, `GAME_RST_HOLD);
        check("led", led, 1'b0);
    endtask

    initial begin
        clk_sys      = 1'b0;
        rst_n        = 1'b0;
        pll_locked   = 1'b0;
        rst_req      = 1'b0;
        downloading  = 1'b0;
        osd_shown    = 1'b0;
        game_led     = 2'b00;
        apb_req      = '0;
        board_joy1   = '0;
        board_joy2   = '0;
        pxl_cen      = 1'b0;
        pix_in       = '0;
        lfsr         = SEED;
        status_model = `STATUS_RESET;
        repeat (2) @(negedge clk_sys);
        rst_n = 1'b1;
        @(negedge clk_sys);
        verify_inputs();
        verify_dips();
        check("pix_out", pix_out, 32'h0);
        check("led", led, 1'b0);
        check("game_rst_n", game_rst_n, 1'b0);
        release_after_lock();
        settings_bus();
        flip_restarts_game();
        joystick_mapping();
        soft_reset_hold();
        video_stream();
        led_behaviour();
        $display("=== PASS ===");
        $finish;
    end

endmodule

/* flist.f */
+incdir+rtl
rtl/board_pkg.sv
rtl/video_pkg.sv
rtl/board_reset.sv
rtl/board_inputs.sv
rtl/board_dip.sv
rtl/board_led.sv
rtl/video_expand.sv
rtl/board_top.sv
sim/board_checker.sv
sim/board_tb.sv

/* Makefile */
# Verilator build and run for the board glue testbench

VERILATOR ?= verilator
TOP       ?= board_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_STR  ?= === PASS ===

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q -- "$(PASS_STR)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
